// ==== hdl/endpoint_cfg.svh ====
`ifndef ENDPOINT_CFG_SVH
`define ENDPOINT_CFG_SVH

// system clock in Hz, one cycle is 100 ns
`define ENDPOINT_CLK_FREQUENCY 10_000_000

// serial bit rate, ten clocks per bit at the clock above
`define ENDPOINT_BAUD_RATE 1_000_000

// number of 32-bit word registers in the target
`define ENDPOINT_REG_COUNT 16

// cycles request_stall stays high once an access begins
`define ENDPOINT_STALL_CYCLES 2

`endif

// ==== hdl/phy_types_pkg.sv ====
package phy_types_pkg;

    // one received serial byte
    typedef logic [7:0] byte_t;

    typedef logic [3:0] bit_count_t; // counts data bits within a byte

    // receiver states, error holds until the next falling edge on the line
    typedef enum logic [2:0] {
        rxs_idle,
        rxs_start,
        rxs_receive,
        rxs_stop,
        rxs_done,
        rxs_error
    } rx_state_e;

endpackage

// ==== hdl/bus_types_pkg.sv ====
package bus_types_pkg;

    // address and data are both full words on the register bus
    typedef logic [31:0] word_t;

    typedef logic [3:0] reg_index_t; // selects one word register

    // frame assembly states of the command FSM
    typedef enum logic [1:0] {
        bus_idle,
        bus_addr,
        bus_data,
        bus_send
    } bus_state_e;

endpackage

// ==== hdl/bus_protocol_if.sv ====
`timescale 1ns/10ps

interface bus_protocol_if;
    import bus_types_pkg::*;

    word_t addr;
    word_t wdata;
    word_t rdata;
    logic  ren;
    logic  wen;
    logic  request_stall; // access completes in the first cycle this is low

    modport requester (
        output addr,
        output wdata,
        output ren,
        output wen,
        input  rdata,
        input  request_stall
    );

    modport responder (
        input  addr,
        input  wdata,
        input  ren,
        input  wen,
        output rdata,
        output request_stall
    );

endinterface

// ==== hdl/uart_byte_rx.sv ====
`timescale 1ns/10ps

`include "endpoint_cfg.svh"

module uart_byte_rx #(
    parameter int frequency = `ENDPOINT_CLK_FREQUENCY,
    parameter int baud_rate = `ENDPOINT_BAUD_RATE
) (
    input  logic                 clk,
    input  logic                 n_rst,
    input  logic                 serial_in,
    output phy_types_pkg::byte_t rx_data,
    output logic                 rx_done,
    output logic                 rx_err
);
    import phy_types_pkg::*;

    localparam int bit_clocks = frequency / baud_rate;
    localparam int half_clocks = bit_clocks / 2;
    localparam int cnt_width = $clog2(bit_clocks);

    // counter reload values, the sample happens when the count reaches zero
    localparam logic [cnt_width-1:0] full_load = cnt_width'(bit_clocks - 1);
    localparam logic [cnt_width-1:0] half_load = cnt_width'(half_clocks - 1);
    localparam bit_count_t last_bit = bit_count_t'(7);

    rx_state_e state;
    logic [1:0] sync_q;
    logic line;
    logic line_prev;
    logic fall;
    logic [cnt_width-1:0] clk_cnt;
    bit_count_t bit_cnt;
    byte_t shift_q;
    logic shift_en;

    // two flops in front of everything, the line idles high
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            sync_q    <= 2'b11;
            line_prev <= 1'b1;
        end else begin
            sync_q    <= {sync_q[0], serial_in};
            line_prev <= line;
        end
    end

    assign line = sync_q[1];
    assign fall = line_prev & ~line; // a new byte only starts on a real falling edge

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state   <= rxs_idle;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            case (state)
                rxs_idle, rxs_error: begin
                    if (fall) begin
                        state   <= rxs_start;
                        clk_cnt <= half_load;
                    end
                end
                rxs_start: begin
                    if (clk_cnt != '0) begin
                        clk_cnt <= clk_cnt - 1'b1;
                    end else if (line) begin
                        state <= rxs_error; // start bit did not last half a bit
                    end else begin
                        state   <= rxs_receive;
                        clk_cnt <= full_load;
                        bit_cnt <= '0;
                    end
                end
                rxs_receive: begin
                    if (clk_cnt != '0) begin
                        clk_cnt <= clk_cnt - 1'b1;
                    end else begin
                        clk_cnt <= full_load;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == last_bit) begin
                            state <= rxs_stop;
                        end
                    end
                end
                rxs_stop: begin
                    if (clk_cnt != '0) begin
                        clk_cnt <= clk_cnt - 1'b1;
                    end else if (line) begin
                        state <= rxs_done;
                    end else begin
                        state <= rxs_error;
                    end
                end
                rxs_done: begin
                    state <= rxs_idle;
                end
                default: begin
                    state <= rxs_idle;
                end
            endcase
        end
    end

    // data arrives least significant bit first
    assign shift_en = (state == rxs_receive) && (clk_cnt == '0);

    always_ff @(posedge clk) begin
        if (shift_en) begin
            shift_q <= {line, shift_q[7:1]};
        end
    end

    assign rx_data = shift_q;
    assign rx_done = (state == rxs_done);
    assign rx_err  = (state == rxs_error);

endmodule

// ==== hdl/bus_command_fsm.sv ====
`timescale 1ns/10ps

module bus_command_fsm (
    input  logic                 clk,
    input  logic                 n_rst,
    input  phy_types_pkg::byte_t rx_data,
    input  logic                 rx_done,
    input  logic                 rx_err,
    bus_protocol_if.requester    bus_if
);
    import bus_types_pkg::*;

    bus_state_e state;
    logic [1:0] byte_cnt;
    logic read_flag;
    logic last_byte;

    assign last_byte = (byte_cnt == 2'd3);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state     <= bus_idle;
            byte_cnt  <= '0;
            read_flag <= 1'b0;
        end else begin
            case (state)
                bus_idle: begin
                    // the command byte, bit 0 picks read or write
                    if (rx_done) begin
                        read_flag <= rx_data[0];
                        byte_cnt  <= '0;
                        state     <= bus_addr;
                    end
                end
                bus_addr: begin
                    if (rx_err) begin
                        state <= bus_idle; // partial frame is thrown away
                    end else if (rx_done) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (last_byte) begin
                            state <= bus_data;
                        end
                    end
                end
                bus_data: begin
                    if (rx_err) begin
                        state <= bus_idle;
                    end else if (rx_done) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (last_byte) begin
                            state <= bus_send;
                        end
                    end
                end
                bus_send: begin
                    if (!bus_if.request_stall) begin
                        state <= bus_idle;
                    end
                end
                default: begin
                    state <= bus_idle;
                end
            endcase
        end
    end

    // address and data bytes come least significant first
    always_ff @(posedge clk) begin
        if (rx_done && state == bus_addr) begin
            bus_if.addr[{byte_cnt, 3'b000} +: 8] <= rx_data;
        end
        if (rx_done && state == bus_data) begin
            bus_if.wdata[{byte_cnt, 3'b000} +: 8] <= rx_data;
        end
    end

    assign bus_if.ren = (state == bus_send) && read_flag;
    assign bus_if.wen = (state == bus_send) && !read_flag;

endmodule

// ==== hdl/register_target.sv ====
`timescale 1ns/10ps

`include "endpoint_cfg.svh"

module register_target (
    input  logic              clk,
    input  logic              n_rst,
    bus_protocol_if.responder bus_if
);
    import bus_types_pkg::*;

    localparam int reg_count = `ENDPOINT_REG_COUNT;
    localparam int stall_cycles = `ENDPOINT_STALL_CYCLES;
    localparam int stall_width = $clog2(stall_cycles + 1);
    localparam logic [stall_width-1:0] stall_last = stall_width'(stall_cycles);

    word_t regs [reg_count];
    reg_index_t index;
    logic in_range;
    logic request;
    logic complete;
    logic [stall_width-1:0] stall_cnt;

    assign request  = bus_if.ren | bus_if.wen;
    assign index    = bus_if.addr[5:2];
    assign in_range = bus_if.addr < word_t'(4 * reg_count); // byte addresses of the bank

    // stall is high from the first request cycle until the count runs out
    assign bus_if.request_stall = request && (stall_cnt != stall_last);
    assign complete = request && !bus_if.request_stall;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            stall_cnt <= '0;
        end else if (!request || complete) begin
            stall_cnt <= '0;
        end else begin
            stall_cnt <= stall_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (complete && bus_if.wen && in_range) begin
            regs[index] <= bus_if.wdata;
        end
    end

    // out of range reads come back as zero
    assign bus_if.rdata = in_range ? regs[index] : '0;

endmodule

// ==== hdl/uart_bus_endpoint.sv ====
`timescale 1ns/10ps

module uart_bus_endpoint (
    input  logic                 clk,
    input  logic                 n_rst,
    input  logic                 serial_in,
    output bus_types_pkg::word_t rdata,
    output logic                 rdata_valid,
    output logic                 frame_error
);
    import phy_types_pkg::*;

    byte_t rx_data;
    logic rx_done;
    logic rx_err;

    bus_protocol_if bus_if ();

    uart_byte_rx rx_i (
        .clk       (clk),
        .n_rst     (n_rst),
        .serial_in (serial_in),
        .rx_data   (rx_data),
        .rx_done   (rx_done),
        .rx_err    (rx_err)
    );

    bus_command_fsm fsm_i (
        .clk     (clk),
        .n_rst   (n_rst),
        .rx_data (rx_data),
        .rx_done (rx_done),
        .rx_err  (rx_err),
        .bus_if  (bus_if.requester)
    );

    register_target target_i (
        .clk    (clk),
        .n_rst  (n_rst),
        .bus_if (bus_if.responder)
    );

    // read data is only meaningful in the cycle the read completes
    assign rdata       = bus_if.rdata;
    assign rdata_valid = bus_if.ren & ~bus_if.request_stall;
    assign frame_error = rx_err;

endmodule

// ==== verif/endpoint_assertions.sv ====
`timescale 1ns/10ps

module endpoint_assertions (
    input logic clk,
    input logic n_rst,
    input logic ren,
    input logic wen,
    input logic request_stall,
    input logic rx_done,
    input logic rx_err
);

    int fail_count = 0;

    // a frame is either a read or a write, never both
    one_request_a: assert property (@(posedge clk) disable iff (!n_rst) !(ren && wen))
        else begin
            fail_count++;
            $error("ren and wen high in the same cycle");
        end

    held_request_a: assert property (@(posedge clk) disable iff (!n_rst)
        request_stall |=> $stable({ren, wen}))
        else begin
            fail_count++;
            $error("ren or wen changed while request_stall was high");
        end

    rx_status_a: assert property (@(posedge clk) disable iff (!n_rst) !(rx_done && rx_err))
        else begin
            fail_count++;
            $error("rx_done and rx_err high in the same cycle");
        end

    stall_needs_request_a: assert property (@(posedge clk) disable iff (!n_rst)
        request_stall |-> (ren || wen))
        else begin
            fail_count++;
            $error("request_stall high with no request on the bus");
        end

    // the FSM leaves the send state right after the completing cycle
    request_ends_a: assert property (@(posedge clk) disable iff (!n_rst)
        (ren || wen) && !request_stall |=> !(ren || wen))
        else begin
            fail_count++;
            $error("request still high after the access completed");
        end

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int period = 100,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic n_rst
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // reset is released on a falling edge, clear of the sampling edge
    initial begin
        n_rst = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;
    end

endmodule

// ==== verif/tb_uart_bus_endpoint.sv ====
`timescale 1ns/10ps

`include "endpoint_cfg.svh"

module tb_uart_bus_endpoint;
    import bus_types_pkg::*;

    localparam int bit_clocks = `ENDPOINT_CLK_FREQUENCY / `ENDPOINT_BAUD_RATE;
    localparam int frame_clocks = 9 * 10 * bit_clocks; // nine bytes of ten bits each
    localparam int test_frames = 28; // whole frames plus the loose bytes of the error tests
    localparam int max_cycles = test_frames * frame_clocks * 5 / 4;
    localparam int reg_count = `ENDPOINT_REG_COUNT;

    logic clk;
    logic n_rst;
    logic serial_in;
    word_t rdata;
    logic rdata_valid;
    logic frame_error;

    word_t model [reg_count];
    word_t expected_words [64]; // one entry per read frame, in send order
    int reads_sent;
    int reads_seen;
    int read_errors;
    int flag_errors;
    int cycles;
    logic [31:0] rng_state;

    tb_clock_gen clock_i (.clk(clk), .n_rst(n_rst));

    uart_bus_endpoint dut_i (
        .clk         (clk),
        .n_rst       (n_rst),
        .serial_in   (serial_in),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .frame_error (frame_error)
    );

    bind uart_bus_endpoint endpoint_assertions assertions_i (
        .clk           (clk),
        .n_rst         (n_rst),
        .ren           (bus_if.ren),
        .wen           (bus_if.wen),
        .request_stall (bus_if.request_stall),
        .rx_done       (rx_done),
        .rx_err        (rx_err)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // entered and left on a falling edge
    task automatic hold_line(input logic level, input int clocks);
        serial_in = level;
        repeat (clocks) @(negedge clk);
    endtask

    task automatic send_byte(input logic [7:0] value, input logic stop_bit);
        hold_line(1'b0, bit_clocks);
        for (int i = 0; i < 8; i++) begin
            hold_line(value[i], bit_clocks); // lsb first
        end
        hold_line(stop_bit, bit_clocks);
    endtask

    task automatic send_frame(input logic read, input word_t addr, input word_t data);
        send_byte({7'h00, read}, 1'b1);
        for (int i = 0; i < 4; i++) begin
            send_byte(addr[8*i +: 8], 1'b1);
        end
        for (int i = 0; i < 4; i++) begin
            send_byte(data[8*i +: 8], 1'b1);
        end
    endtask

    task automatic write_word(input word_t addr, input word_t data);
        send_frame(1'b0, addr, data);
        if (addr < 32'd64) begin
            model[addr[5:2]] = data;
        end
    endtask

    task automatic read_word(input word_t addr);
        expected_words[reads_sent] = (addr < 32'd64) ? model[addr[5:2]] : '0;
        reads_sent++;
        send_frame(1'b1, addr, next_random()); // data bytes of a read are ignored
    endtask

    task automatic wait_reads_done();
        while (reads_seen < reads_sent) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic expect_frame_error(input logic level);
        assert (frame_error == level) else begin
            flag_errors++;
            $display("** Error: frame_error expected %h, got %h", level, frame_error);
        end
    endtask

    // read data is checked in the cycle rdata_valid is high
    initial begin
        reads_seen = 0;
        read_errors = 0;
        forever begin
            @(negedge clk);
            if (n_rst && rdata_valid) begin
                assert (reads_seen < reads_sent) else begin
                    read_errors++;
                    $display("rdata_valid pulsed at %0t with no read frame outstanding", $time);
                end
                if (reads_seen < reads_sent) begin
                    assert (rdata == expected_words[reads_seen]) else begin
                        read_errors++;
                        $display("** Error: rdata expected %08h, got %08h",
                            expected_words[reads_seen], rdata);
                    end
                    reads_seen++;
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", max_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        word_t addrs [8];
        word_t addr;
        word_t data;
        word_t rnd;
        int order [8];
        int j;
        int tmp;

        serial_in = 1'b1;
        reads_sent = 0;
        flag_errors = 0;
        rng_state = 32'd2;
        for (int i = 0; i < reg_count; i++) begin
            model[i] = '0;
        end
        @(posedge n_rst);
        repeat (5) @(negedge clk);

        // registers come out of reset as zero
        read_word(32'h0000_0000);
        read_word(32'h0000_003c);
        wait_reads_done();

        // frames go back to back here, with no idle time between them
        for (int i = 0; i < 8; i++) begin
            rnd = next_random();
            addrs[i] = {26'b0, rnd[3:0], 2'b00};
            write_word(addrs[i], next_random());
            order[i] = i;
        end
        for (int i = 7; i > 0; i--) begin
            rnd = next_random();
            j = int'(rnd % (i + 1));
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 8; i++) begin
            read_word(addrs[order[i]]);
        end
        wait_reads_done();

        // out of range, bits 5:2 still alias onto a real register
        addr = next_random() | 32'h0000_0040;
        write_word(addr, next_random());
        read_word(addr);
        read_word(addr & 32'h0000_003c);
        wait_reads_done();

        // start bit shorter than half a bit
        hold_line(1'b0, bit_clocks / 2 - 2);
        hold_line(1'b1, bit_clocks + 2);
        expect_frame_error(1'b1);
        read_word(addrs[0]);
        expect_frame_error(1'b0);
        send_byte(8'h5a, 1'b0);
        hold_line(1'b1, 5);
        expect_frame_error(1'b1);
        read_word(addrs[1]);
        expect_frame_error(1'b0);
        wait_reads_done();

        // write frame broken in its data bytes
        rnd = next_random();
        addr = {26'b0, rnd[3:0], 2'b00};
        data = next_random();
        send_byte(8'h00, 1'b1);
        for (int i = 0; i < 4; i++) begin
            send_byte(addr[8*i +: 8], 1'b1);
        end
        send_byte(data[7:0], 1'b1);
        send_byte(data[15:8], 1'b1);
        send_byte(data[23:16], 1'b0);
        hold_line(1'b1, 5);
        expect_frame_error(1'b1);
        read_word(addr);
        write_word(addr, data);
        read_word(addr);
        wait_reads_done();
        repeat (20) @(negedge clk);

        $display("errors: %0d read data, %0d frame_error, %0d assertion",
            read_errors, flag_errors, dut_i.assertions_i.fail_count);
        if (read_errors + flag_errors + dut_i.assertions_i.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+hdl
hdl/phy_types_pkg.sv
hdl/bus_types_pkg.sv
hdl/bus_protocol_if.sv
hdl/uart_byte_rx.sv
hdl/bus_command_fsm.sv
hdl/register_target.sv
hdl/uart_bus_endpoint.sv
verif/endpoint_assertions.sv
verif/tb_clock_gen.sv
verif/tb_uart_bus_endpoint.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       = tb_uart_bus_endpoint
FILELIST  = vlog.f
SIM_ARGS  = +verilator+error+limit+1000
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = ALL CHECKS PASSED

SOURCES = $(wildcard hdl/*.sv hdl/*.svh verif/*.sv) $(FILELIST)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
